// ==== files.f ====
+incdir+hw
hw/soc_bus_pkg.sv
hw/periph_pkg.sv
hw/wb_if.sv
hw/wb_decoder.sv
hw/gpio_ctrl.sv
hw/uart_ctrl.sv
hw/board_top.sv
test/board_top_tb.sv

// ==== hw/board_macros.svh ====
// widths and address map for one clock domain; the UART scaler is a 16-bit clocks-per-bit count
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// ======================================================================
// bus widths
`define WB_ADDR_W 8
`define WB_DATA_W 32

// board io
`define GPIO_LED_W 8
`define GPIO_SW_W 4

// address map: page in adr[7:4], register in adr[3:2]
`define PAGE_HI 7
`define PAGE_LO 4
`define PAGE_GPIO 4'h0
`define PAGE_UART 4'h1
`define REG_HI 3
`define REG_LO 2

// uart clocks-per-bit, writes below the minimum are raised to it
`define UART_SCALER_W 16
`define UART_SCALER_RST 16'd16
`define UART_SCALER_MIN 16'd4

`endif

// ==== hw/board_top.sv ====
// single clock and synchronous reset; the host must hold cyc and stb until it sees o_wb_ack
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module board_top
  import soc_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_rst,
  input  logic                   i_wb_cyc,
  input  logic                   i_wb_stb,
  input  logic                   i_wb_we,
  input  wb_addr_t               i_wb_adr,
  input  wb_data_t               i_wb_dat,
  output wb_data_t               o_wb_dat,
  output logic                   o_wb_ack,
  input  logic [`GPIO_SW_W-1:0]  i_gpio_sw,
  output logic [`GPIO_LED_W-1:0] o_gpio_led,
  input  logic                   i_uart_rd,
  output logic                   o_uart_td
);

  // internal links from the decoder to each peripheral
  wb_if gpio_bus ();
  wb_if uart_bus ();

  wb_decoder decoder_i (
    .clk    (clk),
    .i_rst  (i_rst),
    .i_cyc  (i_wb_cyc),
    .i_stb  (i_wb_stb),
    .i_we   (i_wb_we),
    .i_adr  (i_wb_adr),
    .i_dat  (i_wb_dat),
    .o_dat  (o_wb_dat),
    .o_ack  (o_wb_ack),
    .m_gpio (gpio_bus.master),
    .m_uart (uart_bus.master)
  );

  gpio_ctrl gpio_i (
    .clk   (clk),
    .i_rst (i_rst),
    .s_bus (gpio_bus.slave),
    .i_sw  (i_gpio_sw),
    .o_led (o_gpio_led)
  );

  uart_ctrl uart_i (
    .clk   (clk),
    .i_rst (i_rst),
    .s_bus (uart_bus.slave),
    .i_rd  (i_uart_rd),
    .o_td  (o_uart_td)
  );

endmodule

`default_nettype wire

// ==== hw/gpio_ctrl.sv ====
// switches are asynchronous and pass two flops; edge latches see only rising switches
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module gpio_ctrl
  import soc_bus_pkg::*, periph_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_rst,
  wb_if.slave                    s_bus,
  input  logic [`GPIO_SW_W-1:0]  i_sw,
  output logic [`GPIO_LED_W-1:0] o_led
);

  logic                   ack_q;
  wb_data_t               dat_q;
  wb_data_t               rd_data;
  gpio_reg_e              reg_sel;
  logic                   req;
  logic                   wr;
  logic [`GPIO_LED_W-1:0] led_q;
  logic [`GPIO_SW_W-1:0]  sw_meta;
  logic [`GPIO_SW_W-1:0]  sw_sync;
  logic [`GPIO_SW_W-1:0]  sw_prev;
  logic [`GPIO_SW_W-1:0]  sw_rise;
  logic [`GPIO_SW_W-1:0]  edge_q;
  logic [`GPIO_SW_W-1:0]  edge_clr;

  // ======================================================================
  // bus side
  assign req     = s_bus.cyc & s_bus.stb & ~ack_q;
  assign wr      = req & s_bus.we;
  assign reg_sel = gpio_reg_e'(s_bus.adr[`REG_HI:`REG_LO]);

  always_comb begin
    case (reg_sel)
      GPIO_LED:  rd_data = wb_data_t'(led_q);
      GPIO_SW:   rd_data = wb_data_t'(sw_sync);
      GPIO_EDGE: rd_data = wb_data_t'(edge_q);
      default:   rd_data = '0;
    endcase
  end

  // led register updates on the ack edge
  always_ff @(posedge clk) begin
    if (i_rst) begin
      ack_q <= 1'b0;
      led_q <= '0;
    end else begin
      ack_q <= req;
      if (wr && reg_sel == GPIO_LED) begin
        led_q <= s_bus.dat_w[`GPIO_LED_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      dat_q <= rd_data;
    end
  end

  // ======================================================================
  // switch input and edge latches
  assign sw_rise  = sw_sync & ~sw_prev;
  assign edge_clr = (wr && reg_sel == GPIO_EDGE) ? s_bus.dat_w[`GPIO_SW_W-1:0] : '0;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      sw_meta <= '0;
      sw_sync <= '0;
      sw_prev <= '0;
      edge_q  <= '0;
    end else begin
      sw_meta <= i_sw;
      sw_sync <= sw_meta;
      sw_prev <= sw_sync;
      // a new rise wins over a clear in the same cycle
      edge_q  <= (edge_q & ~edge_clr) | sw_rise;
    end
  end

  assign s_bus.ack   = ack_q;
  assign s_bus.dat_r = dat_q;
  assign o_led       = led_q;

endmodule

`default_nettype wire

// ==== hw/periph_pkg.sv ====
// peripheral register indices are adr[3:2] within a page; states for the 8N1 UART only
`default_nettype none

package periph_pkg;

  // gpio registers at 0x00, 0x04, 0x08
  typedef enum logic [1:0] {
    GPIO_LED  = 2'd0,
    GPIO_SW   = 2'd1,
    GPIO_EDGE = 2'd2
  } gpio_reg_e;

  // uart registers at 0x10, 0x14, 0x18, 0x1C
  typedef enum logic [1:0] {
    UART_TXDATA = 2'd0,
    UART_RXDATA = 2'd1,
    UART_STATUS = 2'd2,
    UART_SCALER = 2'd3
  } uart_reg_e;

  // ======================================================================
  // serial state machines
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_e;

endpackage

`default_nettype wire

// ==== hw/soc_bus_pkg.sv ====
// bus-side types only; widths come from the board macros and the map has three targets
`default_nettype none

`include "board_macros.svh"

package soc_bus_pkg;

  // ======================================================================
  // wishbone payload types
  typedef logic [`WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [`WB_DATA_W-1:0] wb_data_t;

  // decoder target, anything outside the two pages falls to none
  typedef enum logic [1:0] {
    SEL_GPIO = 2'd0,
    SEL_UART = 2'd1,
    SEL_NONE = 2'd2
  } periph_sel_e;

endpackage

`default_nettype wire

// ==== hw/uart_ctrl.sv ====
// 8N1 only, one byte of receive holding and no FIFO; TXDATA writes while busy are dropped
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module uart_ctrl
  import soc_bus_pkg::*, periph_pkg::*;
(
  input  logic clk,
  input  logic i_rst,
  wb_if.slave  s_bus,
  input  logic i_rd,
  output logic o_td
);

  logic                      ack_q;
  wb_data_t                  dat_q;
  wb_data_t                  rd_data;
  uart_reg_e                 reg_sel;
  logic                      req;
  logic                      wr;
  logic [`UART_SCALER_W-1:0] scaler_q;
  logic [`UART_SCALER_W-1:0] wr_scaler;

  uart_tx_state_e            tx_state;
  logic [`UART_SCALER_W-1:0] tx_cnt;
  logic [7:0]                tx_shift;
  logic [2:0]                tx_bit;
  logic                      tx_busy;
  logic                      tx_start;
  logic                      td_q;

  uart_rx_state_e            rx_state;
  logic [`UART_SCALER_W-1:0] rx_cnt;
  logic [7:0]                rx_shift;
  logic [2:0]                rx_bit;
  logic                      rx_meta;
  logic                      rx_sync;
  logic                      rx_done;
  logic [7:0]                rx_hold;
  logic                      rx_valid;
  logic                      overrun;
  logic                      rx_clr;

  // ======================================================================
  // register access
  assign req       = s_bus.cyc & s_bus.stb & ~ack_q;
  assign wr        = req & s_bus.we;
  assign reg_sel   = uart_reg_e'(s_bus.adr[`REG_HI:`REG_LO]);
  assign wr_scaler = s_bus.dat_w[`UART_SCALER_W-1:0];
  assign tx_busy   = (tx_state != TX_IDLE);
  assign tx_start  = wr & (reg_sel == UART_TXDATA) & ~tx_busy;
  assign rx_clr    = req & ~s_bus.we & (reg_sel == UART_RXDATA);

  always_comb begin
    case (reg_sel)
      UART_RXDATA: rd_data = wb_data_t'(rx_hold);
      UART_STATUS: rd_data = wb_data_t'({overrun, rx_valid, tx_busy});
      UART_SCALER: rd_data = wb_data_t'(scaler_q);
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      ack_q    <= 1'b0;
      scaler_q <= `UART_SCALER_RST;
    end else begin
      ack_q <= req;
      if (wr && reg_sel == UART_SCALER) begin
        scaler_q <= (wr_scaler < `UART_SCALER_MIN) ? `UART_SCALER_MIN : wr_scaler;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      dat_q <= rd_data;
    end
  end

  // ======================================================================
  // transmitter, each bit held for scaler clocks
  always_ff @(posedge clk) begin
    if (i_rst) begin
      tx_state <= TX_IDLE;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      td_q     <= 1'b1;
    end else begin
      case (tx_state)
        TX_IDLE: begin
          if (tx_start) begin
            td_q     <= 1'b0;
            tx_cnt   <= scaler_q - 1'b1;
            tx_state <= TX_START;
          end
        end
        TX_START: begin
          if (tx_cnt == '0) begin
            td_q     <= tx_shift[0];
            tx_cnt   <= scaler_q - 1'b1;
            tx_bit   <= '0;
            tx_state <= TX_DATA;
          end else begin
            tx_cnt <= tx_cnt - 1'b1;
          end
        end
        TX_DATA: begin
          if (tx_cnt == '0) begin
            tx_cnt <= scaler_q - 1'b1;
            if (tx_bit == 3'd7) begin
              td_q     <= 1'b1;
              tx_state <= TX_STOP;
            end else begin
              td_q   <= tx_shift[1];
              tx_bit <= tx_bit + 1'b1;
            end
          end else begin
            tx_cnt <= tx_cnt - 1'b1;
          end
        end
        default: begin
          if (tx_cnt == '0) begin
            tx_state <= TX_IDLE;
          end else begin
            tx_cnt <= tx_cnt - 1'b1;
          end
        end
      endcase
    end
  end

  // data shifts right so bit 0 is always the next one out
  always_ff @(posedge clk) begin
    if (tx_start) begin
      tx_shift <= s_bus.dat_w[7:0];
    end else if (tx_state == TX_DATA && tx_cnt == '0) begin
      tx_shift <= tx_shift >> 1;
    end
  end

  // ======================================================================
  // receiver, samples mid-bit after the start edge
  assign rx_done = (rx_state == RX_STOP) && (rx_cnt == '0);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_state <= RX_IDLE;
      rx_cnt   <= '0;
      rx_bit   <= '0;
    end else begin
      rx_meta <= i_rd;
      rx_sync <= rx_meta;
      case (rx_state)
        RX_IDLE: begin
          if (!rx_sync) begin
            rx_cnt   <= (scaler_q >> 1) - 1'b1;
            rx_state <= RX_START;
          end
        end
        RX_START: begin
          if (rx_cnt != '0) begin
            rx_cnt <= rx_cnt - 1'b1;
          end else if (!rx_sync) begin
            rx_cnt   <= scaler_q - 1'b1;
            rx_bit   <= '0;
            rx_state <= RX_DATA;
          end else begin
            // glitch, line went back high before mid start
            rx_state <= RX_IDLE;
          end
        end
        RX_DATA: begin
          if (rx_cnt == '0) begin
            rx_cnt <= scaler_q - 1'b1;
            rx_bit <= rx_bit + 1'b1;
            if (rx_bit == 3'd7) begin
              rx_state <= RX_STOP;
            end
          end else begin
            rx_cnt <= rx_cnt - 1'b1;
          end
        end
        default: begin
          if (rx_cnt == '0) begin
            rx_state <= RX_IDLE;
          end else begin
            rx_cnt <= rx_cnt - 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rx_state == RX_DATA && rx_cnt == '0) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
    if (rx_done) begin
      rx_hold <= rx_shift;
    end
  end

  // status flags, a byte landing during a RXDATA read still counts
  always_ff @(posedge clk) begin
    if (i_rst) begin
      rx_valid <= 1'b0;
      overrun  <= 1'b0;
    end else begin
      if (rx_clr) begin
        rx_valid <= 1'b0;
        overrun  <= 1'b0;
      end
      if (rx_done) begin
        rx_valid <= 1'b1;
        if (rx_valid && !rx_clr) begin
          overrun <= 1'b1;
        end
      end
    end
  end

  assign s_bus.ack   = ack_q;
  assign s_bus.dat_r = dat_q;
  assign o_td        = td_q;

endmodule

`default_nettype wire

// ==== hw/wb_decoder.sv ====
// no wait states added; unmapped pages get a registered zero-data ack and never an error
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module wb_decoder
  import soc_bus_pkg::*;
(
  input  logic     clk,
  input  logic     i_rst,
  input  logic     i_cyc,
  input  logic     i_stb,
  input  logic     i_we,
  input  wb_addr_t i_adr,
  input  wb_data_t i_dat,
  output wb_data_t o_dat,
  output logic     o_ack,
  wb_if.master     m_gpio,
  wb_if.master     m_uart
);

  periph_sel_e sel;
  logic        none_ack;

  // ======================================================================
  // page decode
  always_comb begin
    case (i_adr[`PAGE_HI:`PAGE_LO])
      `PAGE_GPIO: sel = SEL_GPIO;
      `PAGE_UART: sel = SEL_UART;
      default:    sel = SEL_NONE;
    endcase
  end

  // request fans out, only the selected slave sees stb
  assign m_gpio.cyc   = i_cyc;
  assign m_gpio.stb   = i_stb & (sel == SEL_GPIO);
  assign m_gpio.we    = i_we;
  assign m_gpio.adr   = i_adr;
  assign m_gpio.dat_w = i_dat;

  assign m_uart.cyc   = i_cyc;
  assign m_uart.stb   = i_stb & (sel == SEL_UART);
  assign m_uart.we    = i_we;
  assign m_uart.adr   = i_adr;
  assign m_uart.dat_w = i_dat;

  // stand-in slave for holes in the map
  always_ff @(posedge clk) begin
    if (i_rst) begin
      none_ack <= 1'b0;
    end else begin
      none_ack <= i_cyc & i_stb & (sel == SEL_NONE) & ~none_ack;
    end
  end

  // response return
  always_comb begin
    case (sel)
      SEL_GPIO: begin
        o_ack = m_gpio.ack;
        o_dat = m_gpio.dat_r;
      end
      SEL_UART: begin
        o_ack = m_uart.ack;
        o_dat = m_uart.dat_r;
      end
      default: begin
        o_ack = none_ack;
        o_dat = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/wb_if.sv ====
// wishbone classic link without err, rty or sel; the slave acks exactly one cycle per request
`timescale 1ns/1ps
`default_nettype none

interface wb_if
  import soc_bus_pkg::*;
();

  logic     cyc;
  logic     stb;
  logic     we;
  wb_addr_t adr;
  wb_data_t dat_w;
  wb_data_t dat_r;
  logic     ack;

  // host side of the link
  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  // peripheral side of the link
  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// ==== test/board_top_tb.sv ====
// uart runs in loopback (td tied to rd); polls assume a scaler of at most 16 clocks per bit
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module board_top_tb;

  localparam int PERIOD     = 4;
  localparam int MAX_SCALER = 16;
  // two frames of ten bits at the slowest scaler plus margin
  localparam int POLL_CLKS  = 2 * 10 * MAX_SCALER + 64;
  localparam int POLL_READS = POLL_CLKS / 2;
  localparam int TABLE_MAX  = 64;

  localparam logic [2:0] OP_WRITE  = 3'd0;
  localparam logic [2:0] OP_READ   = 3'd1;
  localparam logic [2:0] OP_POLL   = 3'd2;
  localparam logic [2:0] OP_SWITCH = 3'd3;
  localparam logic [2:0] OP_WAIT   = 3'd4;

  logic                   clk;
  logic                   i_rst;
  logic                   i_wb_cyc;
  logic                   i_wb_stb;
  logic                   i_wb_we;
  logic [`WB_ADDR_W-1:0]  i_wb_adr;
  logic [`WB_DATA_W-1:0]  i_wb_dat;
  logic [`WB_DATA_W-1:0]  o_wb_dat;
  logic                   o_wb_ack;
  logic [`GPIO_SW_W-1:0]  i_gpio_sw;
  logic [`GPIO_LED_W-1:0] o_gpio_led;
  wire                    uart_line;

  logic [2:0]  tbl_op   [TABLE_MAX];
  logic [7:0]  tbl_addr [TABLE_MAX];
  logic [31:0] tbl_wdat [TABLE_MAX];
  logic [31:0] tbl_exp  [TABLE_MAX];
  logic [31:0] tbl_mask [TABLE_MAX];
  int          n_entries;
  int          err_cnt;
  logic [31:0] rng;

  board_top dut_i (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_wb_cyc   (i_wb_cyc),
    .i_wb_stb   (i_wb_stb),
    .i_wb_we    (i_wb_we),
    .i_wb_adr   (i_wb_adr),
    .i_wb_dat   (i_wb_dat),
    .o_wb_dat   (o_wb_dat),
    .o_wb_ack   (o_wb_ack),
    .i_gpio_sw  (i_gpio_sw),
    .o_gpio_led (o_gpio_led),
    .i_uart_rd  (uart_line),
    .o_uart_td  (uart_line)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // ======================================================================
  // helpers
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      fail_run($sformatf("mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // one classic cycle with the request held until ack and one idle cycle after
  task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int   waited;
    logic ack_seen;
    @(negedge clk);
    // the ack of the previous access lasts a single cycle
    check_value("o_wb_ack", 32'h0, {31'h0, o_wb_ack});
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    waited   = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!o_wb_ack && waited < 4);
    ack_seen = o_wb_ack;
    rdat     = o_wb_dat;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    if (!ack_seen) begin
      fail_run($sformatf("no ack within 4 clocks for access to address 0x%02h", adr));
    end
  endtask

  task automatic add_entry(input logic [2:0] op, input logic [7:0] adr, input logic [31:0] wdat,
                           input logic [31:0] exp, input logic [31:0] mask);
    tbl_op[n_entries]   = op;
    tbl_addr[n_entries] = adr;
    tbl_wdat[n_entries] = wdat;
    tbl_exp[n_entries]  = exp;
    tbl_mask[n_entries] = mask;
    n_entries++;
  endtask

  // ======================================================================
  // stimulus table
  // a write with a nonzero mask also checks the led pins
  task automatic build_table();
    logic [31:0] led_val;
    logic [7:0]  tx_byte;
    logic [7:0]  second_byte;
    // register values out of reset
    add_entry(OP_READ,   8'h00, 32'h0, 32'h0,  32'hffff_ffff);
    add_entry(OP_READ,   8'h18, 32'h0, 32'h0,  32'h7);
    add_entry(OP_READ,   8'h1c, 32'h0, 32'd16, 32'hffff_ffff);
    for (int i = 0; i < 3; i++) begin
      rng     = xorshift32(rng);
      led_val = rng;
      add_entry(OP_WRITE, 8'h00, led_val, {24'h0, led_val[7:0]}, 32'hff);
      add_entry(OP_READ,  8'h00, 32'h0,   {24'h0, led_val[7:0]}, 32'hffff_ffff);
    end
    // switch level then edge latches
    add_entry(OP_SWITCH, 8'h00, 32'ha, 32'h0, 32'h0);
    add_entry(OP_WAIT,   8'h00, 32'd3, 32'h0, 32'h0);
    add_entry(OP_READ,   8'h04, 32'h0, 32'ha, 32'hffff_ffff);
    add_entry(OP_SWITCH, 8'h00, 32'h0, 32'h0, 32'h0);
    add_entry(OP_WAIT,   8'h00, 32'd3, 32'h0, 32'h0);
    add_entry(OP_WRITE,  8'h08, 32'hf, 32'h0, 32'h0);
    add_entry(OP_READ,   8'h08, 32'h0, 32'h0, 32'hffff_ffff);
    add_entry(OP_SWITCH, 8'h00, 32'h5, 32'h0, 32'h0);
    add_entry(OP_WAIT,   8'h00, 32'd3, 32'h0, 32'h0);
    add_entry(OP_READ,   8'h08, 32'h0, 32'h5, 32'hffff_ffff);
    add_entry(OP_WRITE,  8'h08, 32'h5, 32'h0, 32'h0);
    add_entry(OP_READ,   8'h08, 32'h0, 32'h0, 32'hffff_ffff);
    add_entry(OP_SWITCH, 8'h00, 32'h0, 32'h0, 32'h0);
    add_entry(OP_WAIT,   8'h00, 32'd3, 32'h0, 32'h0);
    add_entry(OP_READ,   8'h08, 32'h0, 32'h0, 32'hffff_ffff);
    add_entry(OP_READ,   8'h04, 32'h0, 32'h0, 32'hffff_ffff);
    // scaler clamp then one byte through the loopback
    add_entry(OP_WRITE,  8'h1c, 32'd2, 32'h0, 32'h0);
    add_entry(OP_READ,   8'h1c, 32'h0, 32'd4, 32'hffff_ffff);
    add_entry(OP_WRITE,  8'h1c, 32'd8, 32'h0, 32'h0);
    add_entry(OP_READ,   8'h1c, 32'h0, 32'd8, 32'hffff_ffff);
    rng     = xorshift32(rng);
    tx_byte = rng[7:0];
    add_entry(OP_WRITE,  8'h10, {24'h0, tx_byte}, 32'h0, 32'h0);
    add_entry(OP_READ,   8'h18, 32'h0, 32'h1, 32'h1);
    add_entry(OP_POLL,   8'h18, 32'h0, 32'h2, 32'h2);
    add_entry(OP_READ,   8'h18, 32'h0, 32'h2, 32'h7);
    add_entry(OP_READ,   8'h14, 32'h0, {24'h0, tx_byte}, 32'hffff_ffff);
    add_entry(OP_READ,   8'h18, 32'h0, 32'h0, 32'h7);
    // two bytes without a read in between
    rng         = xorshift32(rng);
    tx_byte     = rng[7:0];
    rng         = xorshift32(rng);
    second_byte = rng[7:0];
    add_entry(OP_WRITE,  8'h10, {24'h0, tx_byte}, 32'h0, 32'h0);
    add_entry(OP_POLL,   8'h18, 32'h0, 32'h0, 32'h1);
    add_entry(OP_WRITE,  8'h10, {24'h0, second_byte}, 32'h0, 32'h0);
    add_entry(OP_POLL,   8'h18, 32'h0, 32'h0, 32'h1);
    add_entry(OP_POLL,   8'h18, 32'h0, 32'h4, 32'h4);
    add_entry(OP_READ,   8'h18, 32'h0, 32'h6, 32'h7);
    add_entry(OP_READ,   8'h14, 32'h0, {24'h0, second_byte}, 32'hffff_ffff);
    add_entry(OP_READ,   8'h18, 32'h0, 32'h0, 32'h7);
    // hole in the address map
    add_entry(OP_READ,   8'h40, 32'h0, 32'h0, 32'hffff_ffff);
    add_entry(OP_WRITE,  8'h40, 32'hffff_ffff, {24'h0, led_val[7:0]}, 32'hff);
    add_entry(OP_READ,   8'h00, 32'h0, {24'h0, led_val[7:0]}, 32'hffff_ffff);
  endtask

  task automatic run_entry(input int idx);
    logic [31:0] rdat;
    int          tries;
    logic        done;
    case (tbl_op[idx])
      OP_WRITE: begin
        bus_cycle(1'b1, tbl_addr[idx], tbl_wdat[idx], rdat);
        if (tbl_mask[idx] != 32'h0) begin
          check_value("o_gpio_led", tbl_exp[idx] & tbl_mask[idx],
                      {24'h0, o_gpio_led} & tbl_mask[idx]);
        end
      end
      OP_READ: begin
        bus_cycle(1'b0, tbl_addr[idx], 32'h0, rdat);
        check_value($sformatf("o_wb_dat@%02h", tbl_addr[idx]),
                    tbl_exp[idx] & tbl_mask[idx], rdat & tbl_mask[idx]);
      end
      OP_POLL: begin
        tries = 0;
        done  = 1'b0;
        while (!done && tries < POLL_READS) begin
          bus_cycle(1'b0, tbl_addr[idx], 32'h0, rdat);
          tries++;
          done = ((rdat & tbl_mask[idx]) == tbl_exp[idx]);
        end
        if (!done) begin
          fail_run($sformatf("entry %0d: register 0x%02h never reached the awaited value",
                             idx, tbl_addr[idx]));
        end
      end
      OP_SWITCH: begin
        @(negedge clk);
        i_gpio_sw = tbl_wdat[idx][`GPIO_SW_W-1:0];
      end
      default: begin
        repeat (tbl_wdat[idx]) @(negedge clk);
      end
    endcase
  endtask

  // ======================================================================
  // main sequence
  initial begin
    i_rst     = 1'b1;
    i_wb_cyc  = 1'b0;
    i_wb_stb  = 1'b0;
    i_wb_we   = 1'b0;
    i_wb_adr  = '0;
    i_wb_dat  = '0;
    i_gpio_sw = '0;
    n_entries = 0;
    err_cnt   = 0;
    rng       = 32'd8;
    build_table();
    repeat (3) @(negedge clk);
    i_rst = 1'b0;
    // idle serial line and dark leds out of reset
    check_value("o_uart_td", 32'h1, {31'h0, o_uart_td_value()});
    check_value("o_gpio_led", 32'h0, {24'h0, o_gpio_led});
    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    if (err_cnt == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      fail_run("errors were counted during the run");
    end
  end

  function automatic logic o_uart_td_value();
    return uart_line;
  endfunction

  // every entry gets at most one long poll worth of clocks
  initial begin
    #1;
    #((n_entries * POLL_CLKS + 32) * PERIOD);
    fail_run("watchdog expired before the test sequence finished");
  end

endmodule

`default_nettype wire
